// ==== rtl/f2d_pkg.sv ====
`default_nettype none

package f2d_pkg;

    localparam int EXP_W        = 8;
    localparam int EXP_BIAS     = 127;
    localparam int INT_EXP_MAX  = 23;
    localparam int FRAC_EXP_MIN = -16;
    localparam int FRAC_EXP_MAX = 15;   // Above this the fraction bits leave the window
    localparam int MANT_W       = 24;   // Hidden bit included
    localparam int FRAC_BITS    = 23;
    localparam int LZ_MAX       = 6;

    // Partial sums per tree level
    localparam int LV0_SUMS = 11;
    localparam int LV1_SUMS = 6;
    localparam int LV2_SUMS = 3;

    // Sequencer encoding
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_LV0  = 3'd1;
    localparam logic [2:0] ST_LV1  = 3'd2;
    localparam logic [2:0] ST_LV2  = 3'd3;
    localparam logic [2:0] ST_LV3  = 3'd4;
    localparam logic [2:0] ST_DONE = 3'd5;
    localparam logic [2:0] ST_ACK  = 3'd6;

    typedef logic [31:0] dec_word_t;

    localparam dec_word_t DEC_SCALE = 32'd1_000_000_000;

    // Truncated 10^9 / 2^k
    localparam dec_word_t FRAC_WEIGHT [1:FRAC_BITS] = '{
        32'd500_000_000, 32'd250_000_000, 32'd125_000_000, 32'd62_500_000,
        32'd31_250_000,  32'd15_625_000,  32'd7_812_500,   32'd3_906_250,
        32'd1_953_125,   32'd976_562,     32'd488_281,     32'd244_140,
        32'd122_070,     32'd61_035,      32'd30_517,      32'd15_258,
        32'd7_629,       32'd3_814,       32'd1_907,       32'd953,
        32'd476,         32'd238,         32'd119
    };

    // One decimal digit per step from 0.1 down to 0.000001
    localparam dec_word_t LZ_THRESH [0:LZ_MAX-1] = '{
        32'd100_000_000, 32'd10_000_000, 32'd1_000_000,
        32'd100_000,     32'd10_000,     32'd1_000
    };

    typedef struct packed {
        logic                 sign;
        logic [EXP_W-1:0]     exponent;
        logic [FRAC_BITS-1:0] fraction;
    } f754_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        f754_fields_t fmt;
    } f754_word_u;

endpackage

`default_nettype wire

// ==== rtl/f2d_field_if.sv ====
`default_nettype none

interface f2d_field_if
    import f2d_pkg::*;
();
    logic signed [EXP_W-1:0]  exp_qual;     // Unbiased exponent
    logic        [MANT_W-1:0] mantissa;
    logic                     is_zero;
    logic                     out_of_range;

    modport src (
        output exp_qual, mantissa, is_zero, out_of_range
    );

    modport dst (
        input exp_qual, mantissa, is_zero
    );

endinterface

`default_nettype wire

// ==== rtl/conv_ctrl.sv ====
`default_nettype none

module conv_ctrl
    import f2d_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    output logic       ack,
    output logic       load,
    output logic [3:0] stage_en
);

    logic [2:0] state;
    logic [2:0] state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_nxt = ST_LV0;
                end
            end
            ST_LV0:  state_nxt = ST_LV1;
            ST_LV1:  state_nxt = ST_LV2;
            ST_LV2:  state_nxt = ST_LV3;
            ST_LV3:  state_nxt = ST_DONE;
            ST_DONE: state_nxt = ST_ACK;    // Result settles through the leading-zero count
            ST_ACK: begin
                if (!req) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign load     = (state == ST_IDLE) && req;  // Word is captured on the accepting edge
    assign stage_en = {state == ST_LV3, state == ST_LV2, state == ST_LV1, state == ST_LV0};
    assign ack      = (state == ST_ACK);

    // Enables walk up one level per cycle behind the load pulse
    a_stage_walk: assert property (@(posedge clk) disable iff (reset)
        stage_en == {$past(stage_en[2:0]), $past(load)});

    // Ack only follows a completed final tree level
    a_ack_after_sum: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> (stage_en == 4'b0000) && $past(stage_en[3], 2));

endmodule

`default_nettype wire

// ==== rtl/float_unpack.sv ====
`default_nettype none

module float_unpack
    import f2d_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        load,
    input  logic [31:0] float_in,
    f2d_field_if.src    fields
);

    f754_word_u word_q;
    int         exp_unb;
    logic       word_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            word_q.raw <= '0;
        end else if (load) begin
            word_q.raw <= float_in;
        end
    end

    // Wide signed exponent so that 0 and 255 stay distinguishable
    assign exp_unb   = int'(word_q.fmt.exponent) - EXP_BIAS;
    assign word_zero = (word_q.raw == '0);

    assign fields.exp_qual     = exp_unb[EXP_W-1:0];
    assign fields.mantissa     = {1'b1, word_q.fmt.fraction};  // Hidden bit
    assign fields.is_zero      = word_zero;
    // Denormals, inf and NaN all land outside the window
    assign fields.out_of_range = !word_zero &&
                                 (exp_unb > INT_EXP_MAX || exp_unb < FRAC_EXP_MIN);

    a_zero_word: assert property (@(posedge clk) disable iff (reset)
        load && (float_in == '0) |=> fields.is_zero && !fields.out_of_range);

endmodule

`default_nettype wire

// ==== rtl/mantissa_split.sv ====
`default_nettype none

module mantissa_split
    import f2d_pkg::*;
(
    f2d_field_if.dst             fields,
    output dec_word_t            int_dec,
    output logic [FRAC_BITS-1:0] frac_bits
);

    always_comb begin
        logic [4:0]        exp_mag;
        logic [MANT_W-1:0] mant_shr;

        // Exponent magnitude is only meaningful in range
        exp_mag  = fields.exp_qual[EXP_W-1] ? 5'(-fields.exp_qual) : 5'(fields.exp_qual);
        mant_shr = fields.mantissa >> exp_mag;

        int_dec   = '0;
        frac_bits = '0;

        if (!fields.is_zero) begin
            if (!fields.exp_qual[EXP_W-1]) begin
                // Binary point sits exp bits below the hidden bit
                int_dec = dec_word_t'(fields.mantissa) >> (5'(FRAC_BITS) - exp_mag);
                if (exp_mag <= 5'(FRAC_EXP_MAX)) begin
                    frac_bits = fields.mantissa[FRAC_BITS-1:0] << exp_mag;
                end
            end else begin
                frac_bits = mant_shr[FRAC_BITS-1:0];    // Hidden bit moves into the fraction
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dec_sum_tree.sv ====
`default_nettype none

module dec_sum_tree
    import f2d_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [3:0]           stage_en,
    input  logic [FRAC_BITS-1:0] frac_bits,
    output dec_word_t            frac_dec
);

    dec_word_t term  [1:FRAC_BITS];
    dec_word_t lv0_d [0:LV0_SUMS-1];
    dec_word_t lv0_q [0:LV0_SUMS-1];
    dec_word_t lv1_d [0:LV1_SUMS-1];
    dec_word_t lv1_q [0:LV1_SUMS-1];
    dec_word_t lv2_d [0:LV2_SUMS-1];
    dec_word_t lv2_q [0:LV2_SUMS-1];
    dec_word_t lv3_d;

    // MSB of frac_bits weighs 2^-1
    always_comb begin
        for (int k = 1; k <= FRAC_BITS; k++) begin
            term[k] = frac_bits[FRAC_BITS-k] ? FRAC_WEIGHT[k] : '0;
        end
    end

    always_comb begin
        for (int i = 0; i < LV0_SUMS; i++) begin
            lv0_d[i] = term[2*i+1] + term[2*i+2];
        end
        lv0_d[LV0_SUMS-1] = lv0_d[LV0_SUMS-1] + term[FRAC_BITS];  // Odd term count
    end

    // Last level-0 sum has no partner and passes straight through
    always_comb begin
        for (int i = 0; i < LV1_SUMS - 1; i++) begin
            lv1_d[i] = lv0_q[2*i] + lv0_q[2*i+1];
        end
        lv1_d[LV1_SUMS-1] = lv0_q[LV0_SUMS-1];
    end

    always_comb begin
        for (int i = 0; i < LV2_SUMS; i++) begin
            lv2_d[i] = lv1_q[2*i] + lv1_q[2*i+1];
        end
    end

    assign lv3_d = lv2_q[0] + lv2_q[1] + lv2_q[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            lv0_q    <= '{default: '0};
            lv1_q    <= '{default: '0};
            lv2_q    <= '{default: '0};
            frac_dec <= '0;
        end else begin
            if (stage_en[0]) begin
                lv0_q <= lv0_d;
            end
            if (stage_en[1]) begin
                lv1_q <= lv1_d;
            end
            if (stage_en[2]) begin
                lv2_q <= lv2_d;
            end
            if (stage_en[3]) begin
                frac_dec <= lv3_d;
            end
        end
    end

    // Truncated weights keep the total below one
    a_frac_below_one: assert property (@(posedge clk) disable iff (reset)
        stage_en[3] |=> frac_dec < DEC_SCALE);

endmodule

`default_nettype wire

// ==== rtl/lead_zero_count.sv ====
`default_nettype none

module lead_zero_count
    import f2d_pkg::*;
(
    input  dec_word_t  frac_dec,
    output logic [2:0] lead0_num
);

    // Each threshold above the value adds one zero digit after the point
    always_comb begin
        lead0_num = '0;
        for (int i = 0; i < LZ_MAX; i++) begin
            if (frac_dec < LZ_THRESH[i] && lead0_num < 3'(LZ_MAX)) begin
                lead0_num = lead0_num + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/f2d_conv_top.sv ====
`default_nettype none

module f2d_conv_top
    import f2d_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  logic [31:0] float_in,
    output logic        ack,
    output dec_word_t   int_dec,
    output dec_word_t   frac_dec,
    output logic [2:0]  lead0_num,
    output logic        overflow
);

    logic                 load;
    logic [3:0]           stage_en;
    logic [FRAC_BITS-1:0] frac_bits;

    f2d_field_if fields ();

    conv_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ack      (ack),
        .load     (load),
        .stage_en (stage_en)
    );

    float_unpack u_unpack (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .float_in (float_in),
        .fields   (fields.src)
    );

    mantissa_split u_split (
        .fields    (fields.dst),
        .int_dec   (int_dec),
        .frac_bits (frac_bits)
    );

    dec_sum_tree u_tree (
        .clk       (clk),
        .reset     (reset),
        .stage_en  (stage_en),
        .frac_bits (frac_bits),
        .frac_dec  (frac_dec)
    );

    lead_zero_count u_lzc (
        .frac_dec  (frac_dec),
        .lead0_num (lead0_num)
    );

    assign overflow = fields.out_of_range;

endmodule

`default_nettype wire

// ==== sim/f2d_ref.svh ====
`ifndef F2D_REF_SVH
`define F2D_REF_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Expected outputs for the magnitude of one input word
function automatic void ref_convert(
    input  logic [31:0] word,
    output logic [31:0] int_e,
    output logic [31:0] frac_e,
    output logic [2:0]  lz_e,
    output logic        ovf_e
);
    int          exp_val;
    logic [63:0] fixed;     // Binary point between bits 39 and 38
    logic [31:0] thresh;

    exp_val = int'(word[30:23]) - EXP_BIAS;
    int_e   = '0;
    frac_e  = '0;
    lz_e    = '0;
    ovf_e   = (word != '0) && (exp_val > INT_EXP_MAX || exp_val < FRAC_EXP_MIN);

    if (!ovf_e && word != '0) begin
        fixed = 64'({1'b1, word[22:0]}) << (exp_val + 16);
        int_e = 32'(fixed[63:39]);
        // Large exponents push the fraction out of the decimal window
        if (exp_val <= FRAC_EXP_MAX) begin
            for (int k = 1; k <= FRAC_BITS; k++) begin
                if (fixed[39-k]) begin
                    frac_e = frac_e + DEC_SCALE / (32'd1 << k);
                end
            end
        end
    end

    // One zero digit for every power of ten from 10^8 to 10^3 above the value
    thresh = DEC_SCALE / 32'd10;
    while (thresh >= 32'd1000) begin
        if (frac_e < thresh && lz_e < 3'(LZ_MAX)) begin
            lz_e = lz_e + 3'd1;
        end
        thresh = thresh / 32'd10;
    end
endfunction

`endif

// ==== sim/tb_f2d.sv ====
`default_nettype none

module tb_f2d
    import f2d_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        req;
    logic [31:0] float_in;
    logic        ack;
    logic [31:0] int_dec;
    logic [31:0] frac_dec;
    logic [2:0]  lead0_num;
    logic        overflow;

    logic [31:0] lfsr_q;
    logic [31:0] word_q [$];   // Requests waiting for their ack
    string       name_q [$];
    int          wait_limit;
    logic        ack_prev;

    `include "f2d_ref.svh"

    f2d_conv_top DUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .float_in  (float_in),
        .ack       (ack),
        .int_dec   (int_dec),
        .frac_dec  (frac_dec),
        .lead0_num (lead0_num),
        .overflow  (overflow)
    );

    always #2 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // One full four-phase handshake with req kept high for hold extra cycles
    task automatic run_conv(input string name, input logic [31:0] word, input int hold,
                            output int rise_cycles, output int fall_cycles);
        logic [31:0] held_frac;

        @(posedge clk);
        #1;
        float_in = word;
        req      = 1'b1;
        word_q.push_back(word);
        name_q.push_back(name);
        @(posedge clk);     // Capturing edge
        #1;
        rise_cycles = 0;
        while (!ack) begin
            if (rise_cycles >= wait_limit) begin
                $display("TEST FAILED");
                $fatal(1, "Timed out waiting for ack to rise on %s", name);
            end
            @(posedge clk);
            #1;
            rise_cycles++;
        end
        held_frac = frac_dec;
        for (int h = 0; h < hold; h++) begin
            @(posedge clk);
            #1;
            check_val({name, " ack held"}, 32'd1, 32'(ack));
            check_val({name, " frac held"}, held_frac, frac_dec);
        end
        req         = 1'b0;
        fall_cycles = 0;
        while (ack) begin
            if (fall_cycles >= wait_limit) begin
                $display("TEST FAILED");
                $fatal(1, "Timed out waiting for ack to fall on %s", name);
            end
            @(posedge clk);
            #1;
            fall_cycles++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        logic [31:0] m_word;
        string       m_name;
        logic [31:0] m_int;
        logic [31:0] m_frac;
        logic [2:0]  m_lz;
        logic        m_ovf;
        logic        rising;

        rising   = ack && !ack_prev;
        ack_prev = ack;
        if (rising) begin
            if (word_q.size() == 0) begin
                $display("TEST FAILED");
                $fatal(1, "ack rose with no request outstanding");
            end else begin
                m_word = word_q.pop_front();
                m_name = name_q.pop_front();
                ref_convert(m_word, m_int, m_frac, m_lz, m_ovf);
                check_val({m_name, " overflow"}, 32'(m_ovf), 32'(overflow));
                if (!m_ovf) begin   // Numbers are undefined out of range
                    check_val({m_name, " int_dec"}, m_int, int_dec);
                    check_val({m_name, " frac_dec"}, m_frac, frac_dec);
                    check_val({m_name, " lead0_num"}, 32'(m_lz), 32'(lead0_num));
                end
            end
        end
    end

    initial begin
        logic [31:0] e_int;
        logic [31:0] e_frac;
        logic [2:0]  e_lz;
        logic        e_ovf;
        logic [31:0] word;
        int          rise;
        int          fall;
        int          exp_span;

        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        float_in    = '0;
        lfsr_q      = 32'hfac7_6c4b;
        wait_limit  = 40;
        ack_prev    = 1'b0;
        exp_span    = INT_EXP_MAX - FRAC_EXP_MIN + 1;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_val("ack after reset", 32'd0, 32'(ack));

        // Spot checks on the reference model
        ref_convert(32'h4070_0000, e_int, e_frac, e_lz, e_ovf);
        check_val("ref 3.75 int", 32'd3, e_int);
        check_val("ref 3.75 frac", 32'd750_000_000, e_frac);
        ref_convert(32'h3780_0000, e_int, e_frac, e_lz, e_ovf);
        check_val("ref 2^-16 lead0", 32'd4, 32'(e_lz));

        run_conv("timing 1.0", 32'h3f80_0000, 3, rise, fall);
        check_val("ack latency", 32'd5, 32'(rise));
        check_val("ack release", 32'd1, 32'(fall));

        run_conv("0.5", 32'h3f00_0000, 0, rise, fall);
        run_conv("3.75", 32'h4070_0000, 0, rise, fall);
        run_conv("2^23", 32'h4b00_0000, 0, rise, fall);
        run_conv("2^-16", 32'h3780_0000, 0, rise, fall);
        run_conv("0.001", 32'h3a83_126f, 1, rise, fall);
        run_conv("zero", 32'h0000_0000, 0, rise, fall);
        run_conv("2.5", 32'h4020_0000, 0, rise, fall);
        run_conv("-2.5", 32'hc020_0000, 0, rise, fall);

        run_conv("2^24", 32'h4b80_0000, 0, rise, fall);
        run_conv("2^-17", 32'h3700_0000, 0, rise, fall);
        run_conv("infinity", 32'h7f80_0000, 0, rise, fall);
        run_conv("nan", 32'h7fc0_0000, 0, rise, fall);
        run_conv("denormal", 32'h0000_0001, 0, rise, fall);
        run_conv("max float", 32'h7f7f_ffff, 0, rise, fall);

        for (int n = 0; n < 200; n++) begin
            word = take_bits(FRAC_BITS + 1);   // Sign lands in bit 23
            word = {word[23], 8'(EXP_BIAS + FRAC_EXP_MIN + int'(take_bits(6)) % exp_span),
                    word[22:0]};
            run_conv($sformatf("random %0d", n), word, 0, rise, fall);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== f2d_conv.f ====
+incdir+sim
rtl/f2d_pkg.sv
rtl/f2d_field_if.sv
rtl/conv_ctrl.sv
rtl/float_unpack.sv
rtl/mantissa_split.sv
rtl/dec_sum_tree.sv
rtl/lead_zero_count.sv
rtl/f2d_conv_top.sv
sim/tb_f2d.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_f2d
FILELIST  := f2d_conv.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
